// ==== Makefile ====
# Verilator build of the rename stage testbench; the run target returns the simulator status

SRCS := $(shell cat compile.f)

all: run

obj_dir/VrenameTb: compile.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module renameTb -f compile.f

run: obj_dir/VrenameTb
	./obj_dir/VrenameTb

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== bench/renameTb.sv ====
// directed testbench for renameTop with a map and free-list model; run through the Makefile
`timescale 1ns/10ps

module renameTb;

  import renamePkg::*;

  localparam int CYCLE_LIMIT = 2000;  // five tests need about 200 cycles

  logic          clk;
  logic          arstN;
  logic          decodeReady;
  decodedGroup_t decodedGroup;
  commitGroup_t  commitGroup;
  logic          recoverFlag;
  recoverGroup_t recoverGroup;
  logic          stall;
  renamedGroup_t renamedGroup;
  logic          renamedValid;
  logic          renameReady;
  logic          freeListShort;

  phyReg_t       mapModel [NUM_LOGICAL];
  phyReg_t       freeQ [$];  // speculative free list
  phyReg_t       retQ [$];   // retired ring, always FREE_LIST_SIZE entries
  renamedGroup_t expQ [$];   // groups the output still owes
  string         testName;
  int            cycles;

  renameTop dut0 (
    .clk             (clk),
    .arstN_i         (arstN),
    .decodeReady_i   (decodeReady),
    .decodedGroup_i  (decodedGroup),
    .commitGroup_i   (commitGroup),
    .recoverFlag_i   (recoverFlag),
    .recoverGroup_i  (recoverGroup),
    .stall_i         (stall),
    .renamedGroup_o  (renamedGroup),
    .renamedValid_o  (renamedValid),
    .renameReady_o   (renameReady),
    .freeListShort_o (freeListShort)
  );

  always #5 clk = ~clk;

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
      stopRun("timeout: cycle limit reached before the tests finished");
  end

  task automatic checkRenamed(input string what, input renamedInst_t exp,
                              input renamedInst_t act);
    if (exp !== act)
      stopRun($sformatf("FAILED %s: expected %h, actual %h", what, exp, act));
  endtask

  task automatic checkFlag(input string what, input logic exp, input logic act);
    if (exp !== act)
      stopRun($sformatf("FAILED %s: expected %b, actual %b", what, exp, act));
  endtask

  task automatic checkPhy(input string what, input phyReg_t exp, input phyReg_t act);
    if (exp !== act)
      stopRun($sformatf("FAILED %s: expected %0d, actual %0d", what, exp, act));
  endtask

  // a group leaves on the next edge when valid and not stalled
  always @(negedge clk)
  begin
    if (renamedValid && !stall && !recoverFlag)
    begin
      if (expQ.size() == 0)
        stopRun("a group left the output stage that was never accepted");
      else
      begin
        for (int k = 0; k < RENAME_WIDTH; k++)
          checkRenamed($sformatf("%s slot %0d", testName, k), expQ[0][k], renamedGroup[k]);
        expQ.delete(0);
      end
    end
  end

  task automatic modelReset();
    freeQ.delete();
    for (int r = 0; r < NUM_LOGICAL; r++)
      mapModel[r] = phyReg_t'(r);
    for (int i = 0; i < FREE_LIST_SIZE; i++)
      freeQ.push_back(phyReg_t'(NUM_LOGICAL + i));
    retQ = freeQ;
  endtask

  // slots renamed one after another, so later slots see earlier writes
  task automatic modelRename(input decodedGroup_t g, output renamedGroup_t r);
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      r[k].destLog    = g[k].destLog;
      r[k].hasDest    = g[k].hasDest;
      r[k].isBranch   = g[k].isBranch;
      r[k].isStore    = g[k].isStore;
      r[k].isLoad     = g[k].isLoad;
      r[k].immediate  = g[k].immediate;
      r[k].ldstSize   = g[k].ldstSize;
      r[k].fu         = g[k].fu;
      r[k].pc         = g[k].pc;
      r[k].src1Phy    = mapModel[g[k].src1Log];
      r[k].src2Phy    = mapModel[g[k].src2Log];
      r[k].oldDestPhy = mapModel[g[k].destLog];
      r[k].destPhy    = '0;
      if (g[k].hasDest)
      begin
        r[k].destPhy = freeQ.pop_front();
        mapModel[g[k].destLog] = r[k].destPhy;
      end
    end
  endtask

  function automatic decodedInst_t makeInst(input logic hasDest, input int dest, input int s1,
                                            input int s2, input logic [31:0] pc);
    decodedInst_t d;
    d.hasDest   = hasDest;
    d.destLog   = logReg_t'(dest);
    d.src1Log   = logReg_t'(s1);
    d.src2Log   = logReg_t'(s2);
    d.immediate = pc[15:0] ^ 16'h5a3c;
    d.fu        = pc[3:2];
    d.ldstSize  = pc[5:4];
    d.isLoad    = pc[6];
    d.isStore   = pc[7];
    d.isBranch  = pc[8];
    d.pc        = pc;
    return d;
  endfunction

  function automatic int randLog();
    return int'($urandom_range(31, 1));
  endfunction

  // returns on the edge that accepted the group
  task automatic sendGroup(input decodedGroup_t g);
    renamedGroup_t exp;
    @(posedge clk);
    decodeReady  <= 1'b1;
    decodedGroup <= g;
    @(negedge clk);
    while (!renameReady)
      @(negedge clk);
    modelRename(g, exp);
    expQ.push_back(exp);
    @(posedge clk);
    decodeReady <= 1'b0;
  endtask

  task automatic commitRegs(input phyGroup_t regs, input logic [RENAME_WIDTH-1:0] mask);
    @(posedge clk);
    for (int p = 0; p < RENAME_WIDTH; p++)
    begin
      commitGroup[p].valid  <= mask[p];
      commitGroup[p].phyReg <= regs[p];
    end
    @(posedge clk);
    commitGroup <= '0;
    for (int p = 0; p < RENAME_WIDTH; p++)
    begin
      if (mask[p])
      begin
        freeQ.push_back(regs[p]);
        retQ.delete(0);  // in-order commit retires the oldest entry
        retQ.push_back(regs[p]);
      end
    end
    @(negedge clk);
    checkFlag($sformatf("%s commit short flag", testName), freeQ.size() < RENAME_WIDTH,
              freeListShort);
  endtask

  task automatic drainOutput();
    while (expQ.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic testReset();
    decodedGroup_t g;
    testName = "reset";
    @(negedge clk);
    checkFlag("reset ready", 1'b1, renameReady);
    checkFlag("reset short", 1'b0, freeListShort);
    checkFlag("reset valid", 1'b0, renamedValid);
    for (int k = 0; k < RENAME_WIDTH; k++)
      g[k] = makeInst(1'b1, k + 1, k + 5, k + 9, 32'h1000 + 4 * k);
    sendGroup(g);
    @(negedge clk);
    checkFlag("reset group valid", 1'b1, renamedValid);
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      checkPhy("reset destPhy", phyReg_t'(NUM_LOGICAL + k), renamedGroup[k].destPhy);
      checkPhy("reset oldDestPhy", phyReg_t'(k + 1), renamedGroup[k].oldDestPhy);
      checkPhy("reset src1Phy", phyReg_t'(k + 5), renamedGroup[k].src1Phy);
      checkPhy("reset src2Phy", phyReg_t'(k + 9), renamedGroup[k].src2Phy);
    end
    drainOutput();
  endtask

  task automatic testBypass();
    decodedGroup_t g;
    phyReg_t       first;
    phyReg_t       third;
    testName = "bypass";
    first = freeQ[0];
    third = freeQ[2];
    g[0] = makeInst(1'b1, 3, 1, 2, 32'h2000);
    g[1] = makeInst(1'b1, 7, 8, 9, 32'h2004);
    g[2] = makeInst(1'b1, 3, 3, 7, 32'h2008);  // reads and rewrites r3
    g[3] = makeInst(1'b0, 0, 3, 7, 32'h200c);
    sendGroup(g);
    @(negedge clk);
    checkPhy("bypass slot2 src1", first, renamedGroup[2].src1Phy);
    checkPhy("bypass slot2 oldDest", first, renamedGroup[2].oldDestPhy);
    checkPhy("bypass slot3 src1", third, renamedGroup[3].src1Phy);
    drainOutput();
    g[0] = makeInst(1'b1, 3, 3, 7, 32'h2010);
    for (int k = 1; k < RENAME_WIDTH; k++)
      g[k] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h2010 + 4 * k);
    sendGroup(g);
    @(negedge clk);
    checkPhy("bypass next group src1", third, renamedGroup[0].src1Phy);
    drainOutput();
  endtask

  task automatic testBackPressure();
    decodedGroup_t a;
    decodedGroup_t b;
    testName = "backpressure";
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      a[k] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h3000 + 4 * k);
      b[k] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h3100 + 4 * k);
    end
    @(posedge clk);
    stall <= 1'b1;
    sendGroup(a);
    fork
      sendGroup(b);  // waits until the stall is released
      begin
        repeat (4)
        begin
          @(negedge clk);
          checkFlag("backpressure ready", 1'b0, renameReady);
          checkFlag("backpressure valid", 1'b1, renamedValid);
          for (int k = 0; k < RENAME_WIDTH; k++)
            checkRenamed("backpressure hold", expQ[0][k], renamedGroup[k]);
        end
        @(posedge clk);
        stall <= 1'b0;
      end
    join
    drainOutput();
  endtask

  task automatic testExhaustion();
    decodedGroup_t g;
    phyGroup_t     regs;
    phyGroup_t     order;
    int            left;
    int            n;
    testName = "exhaustion";
    n = 0;
    @(negedge clk);
    checkFlag("exhaustion short", freeQ.size() < RENAME_WIDTH, freeListShort);
    while (!freeListShort)
    begin
      for (int k = 0; k < RENAME_WIDTH; k++)
        g[k] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h4000 + 64 * n + 4 * k);
      sendGroup(g);
      n++;
      @(negedge clk);
      checkFlag("exhaustion short", freeQ.size() < RENAME_WIDTH, freeListShort);
    end
    checkFlag("exhaustion ready", 1'b0, renameReady);
    drainOutput();
    left = freeQ.size();
    regs[0]  = 6'd4;
    regs[1]  = 6'd3;
    regs[2]  = 6'd2;
    regs[3]  = 6'd1;
    order[0] = 6'd4;  // ports 0 and 2 first, then 1 and 3
    order[1] = 6'd2;
    order[2] = 6'd3;
    order[3] = 6'd1;
    commitRegs(regs, 4'b0101);
    commitRegs(regs, 4'b1010);
    checkFlag("exhaustion ready after commit", 1'b1, renameReady);
    for (int k = 0; k < RENAME_WIDTH; k++)
      g[k] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h4800 + 4 * k);
    sendGroup(g);
    @(negedge clk);
    for (int k = left; k < RENAME_WIDTH; k++)
      checkPhy("exhaustion commit order", order[k - left], renamedGroup[k].destPhy);
    drainOutput();
  endtask

  task automatic testRecovery();
    decodedGroup_t g;
    recoverGroup_t rec;
    phyGroup_t     regs;
    phyReg_t       head;
    phyReg_t       expSrc;
    testName = "recovery";
    for (int p = 0; p < RENAME_WIDTH; p++)
    begin
      rec[p].valid   = 1'b1;
      rec[p].destLog = logReg_t'(randLog());
      rec[p].phyMap  = phyReg_t'($urandom_range(NUM_PHYSICAL - 1, 0));
      regs[p]        = phyReg_t'(5 + p);
      g[p] = makeInst(1'b1, randLog(), randLog(), randLog(), 32'h5000 + 4 * p);
    end
    commitRegs(regs, 4'b1111);  // room for a wrong-path group
    @(posedge clk);
    stall <= 1'b1;
    sendGroup(g);
    @(posedge clk);
    recoverFlag  <= 1'b1;
    recoverGroup <= rec;
    @(negedge clk);
    checkFlag("recovery ready during flush", 1'b0, renameReady);
    @(posedge clk);
    recoverFlag  <= 1'b0;
    recoverGroup <= '0;
    stall        <= 1'b0;
    for (int p = 0; p < RENAME_WIDTH; p++)
      mapModel[rec[p].destLog] = rec[p].phyMap;  // later port wins
    freeQ = retQ;
    expQ.delete();
    @(negedge clk);
    checkFlag("recovery valid cleared", 1'b0, renamedValid);
    checkFlag("recovery ready", 1'b1, renameReady);
    head   = retQ[0];
    expSrc = mapModel[rec[0].destLog];
    for (int k = 0; k < RENAME_WIDTH; k++)
      g[k] = makeInst(1'b1, randLog(), rec[k].destLog, rec[3 - k].destLog, 32'h5100 + 4 * k);
    sendGroup(g);
    @(negedge clk);
    checkPhy("recovery src1", expSrc, renamedGroup[0].src1Phy);
    checkPhy("recovery restart", head, renamedGroup[0].destPhy);
    drainOutput();
  endtask

  initial
  begin
    void'($urandom(32'h533b8bdc));
    clk          = 1'b0;
    cycles       = 0;
    arstN        = 1'b0;
    decodeReady  = 1'b0;
    decodedGroup = '0;
    commitGroup  = '0;
    recoverFlag  = 1'b0;
    recoverGroup = '0;
    stall        = 1'b0;
    testName     = "init";
    modelReset();
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    testReset();
    testBypass();
    testBackPressure();
    testExhaustion();
    testRecovery();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== bench/renameTop_properties.sv ====
// concurrent checks on the rename handshake and free-list count, bound into renameTop
`timescale 1ns/10ps

module renameTop_properties (
  input logic                     clk,
  input logic                     arstN_i,
  input logic                     stall_i,
  input logic                     recoverFlag_i,
  input logic                     renamedValid_i,
  input renamePkg::renamedGroup_t renamedGroup_i,
  input renamePkg::flCount_t      freeCount_i
);

  import renamePkg::*;

  // nothing in the output register right after reset
  validLowAfterReset: assert property (@(posedge clk) $rose(arstN_i) |-> !renamedValid_i)
    else $error("renamed group valid right after reset");

  // held group may only be dropped by recovery
  holdUnderStall: assert property (@(posedge clk) disable iff (!arstN_i)
    (renamedValid_i && stall_i && !recoverFlag_i) |=> (renamedValid_i && $stable(renamedGroup_i)))
    else $error("output group changed while stalled");

  // a group taken while short would wrap the count past the list size
  countInRange: assert property (@(posedge clk) disable iff (!arstN_i)
    freeCount_i <= flCount_t'(FREE_LIST_SIZE))
    else $error("free-list count above the list size");

endmodule

bind renameTop renameTop_properties props0 (
  .clk            (clk),
  .arstN_i        (arstN_i),
  .stall_i        (stall_i),
  .recoverFlag_i  (recoverFlag_i),
  .renamedValid_i (renamedValid_o),
  .renamedGroup_i (renamedGroup_o),
  .freeCount_i    (freeCount)
);

// ==== compile.f ====
hdl/renamePkg.sv
hdl/specFreeList.sv
hdl/renameMapTable.sv
hdl/renameOutStage.sv
hdl/renameTop.sv
bench/renameTop_properties.sv
bench/renameTb.sv

// ==== hdl/renameMapTable.sv ====
// logical to physical map table with in-group bypass, rename writes and recovery writes
`timescale 1ns/10ps

module renameMapTable (
  input  logic                     clk,
  input  logic                     arstN_i,
  input  renamePkg::decodedGroup_t group_i,
  input  renamePkg::phyGroup_t     freeRegs_i,
  input  logic                     write_i,
  input  logic                     recoverFlag_i,
  input  renamePkg::recoverGroup_t recoverGroup_i,
  output renamePkg::phyGroup_t     src1Phy_o,
  output renamePkg::phyGroup_t     src2Phy_o,
  output renamePkg::phyGroup_t     oldDestPhy_o
);

  import renamePkg::*;

  phyReg_t mapTable [NUM_LOGICAL];

  always_comb
  begin
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      src1Phy_o[k]    = mapTable[group_i[k].src1Log];
      src2Phy_o[k]    = mapTable[group_i[k].src2Log];
      oldDestPhy_o[k] = mapTable[group_i[k].destLog];

      // walk earlier slots in order so the latest writer wins
      for (int j = 0; j < k; j++)
      begin
        if (group_i[j].hasDest)
        begin
          if (group_i[j].destLog == group_i[k].src1Log)
            src1Phy_o[k] = freeRegs_i[j];
          if (group_i[j].destLog == group_i[k].src2Log)
            src2Phy_o[k] = freeRegs_i[j];
          if (group_i[j].destLog == group_i[k].destLog)
            oldDestPhy_o[k] = freeRegs_i[j];  // WAW inside the group
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      for (int r = 0; r < NUM_LOGICAL; r++)
        mapTable[r] <= phyReg_t'(r);  // identity
    end
    else if (recoverFlag_i)
    begin
      // higher port lands last
      for (int p = 0; p < RENAME_WIDTH; p++)
      begin
        if (recoverGroup_i[p].valid)
          mapTable[recoverGroup_i[p].destLog] <= recoverGroup_i[p].phyMap;
      end
    end
    else if (write_i)
    begin
      for (int k = 0; k < RENAME_WIDTH; k++)
      begin
        if (group_i[k].hasDest)
          mapTable[group_i[k].destLog] <= freeRegs_i[k];  // last slot wins
      end
    end
  end

endmodule

// ==== hdl/renameOutStage.sv ====
// one-entry output register for the renamed group; holds under stall, clears on recovery
`timescale 1ns/10ps

module renameOutStage (
  input  logic                     clk,
  input  logic                     arstN_i,
  input  logic                     load_i,
  input  logic                     flush_i,
  input  logic                     stall_i,
  input  renamePkg::renamedGroup_t group_i,
  output logic                     canLoad_o,
  output logic                     valid_o,
  output renamePkg::renamedGroup_t group_o
);

  import renamePkg::*;

  logic          validQ;
  renamedGroup_t groupQ;

  // empty, or the current group leaves this edge
  assign canLoad_o = ~validQ | ~stall_i;

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
      validQ <= 1'b0;
    else if (flush_i)
      validQ <= 1'b0;
    else if (load_i)
      validQ <= 1'b1;
    else if (!stall_i)
      validQ <= 1'b0;  // drained
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
      groupQ <= group_i;
  end

  assign valid_o = validQ;
  assign group_o = groupQ;

endmodule

// ==== hdl/renamePkg.sv ====
// sizes, register types and packet structs shared by the rename stage RTL and its testbench
package renamePkg;

  localparam int RENAME_WIDTH   = 4;   // instructions per group
  localparam int NUM_LOGICAL    = 32;
  localparam int NUM_PHYSICAL   = 64;
  localparam int FREE_LIST_SIZE = NUM_PHYSICAL - NUM_LOGICAL;
  localparam int LOG_W          = 5;
  localparam int PHY_W          = 6;
  localparam int FL_PTR_W       = 5;
  localparam int IMM_W          = 16;
  localparam int FU_W           = 2;
  localparam int LDST_W         = 2;
  localparam int PC_W           = 32;

  typedef logic [LOG_W-1:0]  logReg_t;
  typedef logic [PHY_W-1:0]  phyReg_t;
  typedef logic [FL_PTR_W:0] flCount_t;  // 0 .. FREE_LIST_SIZE

  // packet from decode
  typedef struct packed {
    logic              hasDest;
    logReg_t           destLog;
    logReg_t           src1Log;
    logReg_t           src2Log;
    logic [IMM_W-1:0]  immediate;
    logic [FU_W-1:0]   fu;
    logic [LDST_W-1:0] ldstSize;
    logic              isLoad;
    logic              isStore;
    logic              isBranch;
    logic [PC_W-1:0]   pc;
  } decodedInst_t;

  // packet toward dispatch
  typedef struct packed {
    logReg_t           destLog;
    logic              hasDest;
    logic              isBranch;
    logic              isStore;
    logic              isLoad;
    phyReg_t           oldDestPhy;  // freed when this instruction commits
    phyReg_t           destPhy;
    phyReg_t           src2Phy;
    phyReg_t           src1Phy;
    logic [IMM_W-1:0]  immediate;
    logic [LDST_W-1:0] ldstSize;
    logic [FU_W-1:0]   fu;
    logic [PC_W-1:0]   pc;
  } renamedInst_t;

  typedef decodedInst_t [RENAME_WIDTH-1:0] decodedGroup_t;
  typedef renamedInst_t [RENAME_WIDTH-1:0] renamedGroup_t;
  typedef phyReg_t      [RENAME_WIDTH-1:0] phyGroup_t;

  typedef struct packed {
    logic    valid;
    phyReg_t phyReg;
  } commitPort_t;

  typedef struct packed {
    logic    valid;
    logReg_t destLog;
    phyReg_t phyMap;
  } recoverPort_t;

  typedef commitPort_t  [RENAME_WIDTH-1:0] commitGroup_t;
  typedef recoverPort_t [RENAME_WIDTH-1:0] recoverGroup_t;

endpackage

// ==== hdl/renameTop.sv ====
// rename stage top: accept/ready logic and renamed packet assembly around map table and free list
`timescale 1ns/10ps

module renameTop (
  input  logic                     clk,
  input  logic                     arstN_i,
  input  logic                     decodeReady_i,
  input  renamePkg::decodedGroup_t decodedGroup_i,
  input  renamePkg::commitGroup_t  commitGroup_i,
  input  logic                     recoverFlag_i,
  input  renamePkg::recoverGroup_t recoverGroup_i,
  input  logic                     stall_i,
  output renamePkg::renamedGroup_t renamedGroup_o,
  output logic                     renamedValid_o,
  output logic                     renameReady_o,
  output logic                     freeListShort_o
);

  import renamePkg::*;

  logic [RENAME_WIDTH-1:0] destMask;
  phyGroup_t               freeRegs;
  phyGroup_t               src1Phy;
  phyGroup_t               src2Phy;
  phyGroup_t               oldDestPhy;
  flCount_t                freeCount;
  logic                    canLoad;
  logic                    accept;
  renamedGroup_t           renamedGroup;

  // a full group of four is always reserved, whatever its dest count
  assign freeListShort_o = freeCount < flCount_t'(RENAME_WIDTH);
  assign renameReady_o   = ~freeListShort_o & canLoad & ~recoverFlag_i;
  assign accept          = decodeReady_i & renameReady_o;

  always_comb
  begin
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      destMask[k]                = decodedGroup_i[k].hasDest;
      renamedGroup[k].destLog    = decodedGroup_i[k].destLog;
      renamedGroup[k].hasDest    = decodedGroup_i[k].hasDest;
      renamedGroup[k].isBranch   = decodedGroup_i[k].isBranch;
      renamedGroup[k].isStore    = decodedGroup_i[k].isStore;
      renamedGroup[k].isLoad     = decodedGroup_i[k].isLoad;
      renamedGroup[k].oldDestPhy = oldDestPhy[k];
      renamedGroup[k].destPhy    = decodedGroup_i[k].hasDest ? freeRegs[k] : '0;
      renamedGroup[k].src2Phy    = src2Phy[k];
      renamedGroup[k].src1Phy    = src1Phy[k];
      renamedGroup[k].immediate  = decodedGroup_i[k].immediate;
      renamedGroup[k].ldstSize   = decodedGroup_i[k].ldstSize;
      renamedGroup[k].fu         = decodedGroup_i[k].fu;
      renamedGroup[k].pc         = decodedGroup_i[k].pc;
    end
  end

  specFreeList freeList0 (
    .clk           (clk),
    .arstN_i       (arstN_i),
    .allocate_i    (accept),
    .destMask_i    (destMask),
    .commitGroup_i (commitGroup_i),
    .recoverFlag_i (recoverFlag_i),
    .freeRegs_o    (freeRegs),
    .count_o       (freeCount)
  );

  renameMapTable rmt0 (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .group_i        (decodedGroup_i),
    .freeRegs_i     (freeRegs),
    .write_i        (accept),
    .recoverFlag_i  (recoverFlag_i),
    .recoverGroup_i (recoverGroup_i),
    .src1Phy_o      (src1Phy),
    .src2Phy_o      (src2Phy),
    .oldDestPhy_o   (oldDestPhy)
  );

  renameOutStage outStage0 (
    .clk       (clk),
    .arstN_i   (arstN_i),
    .load_i    (accept),
    .flush_i   (recoverFlag_i),  // wrong-path group dropped
    .stall_i   (stall_i),
    .group_i   (renamedGroup),
    .canLoad_o (canLoad),
    .valid_o   (renamedValid_o),
    .group_o   (renamedGroup_o)
  );

endmodule

// ==== hdl/specFreeList.sv ====
// speculative free list of physical registers; hands out up to four per group, takes commits back
`timescale 1ns/10ps

module specFreeList (
  input  logic                                clk,
  input  logic                                arstN_i,
  input  logic                                allocate_i,
  input  logic [renamePkg::RENAME_WIDTH-1:0]  destMask_i,
  input  renamePkg::commitGroup_t             commitGroup_i,
  input  logic                                recoverFlag_i,
  output renamePkg::phyGroup_t                freeRegs_o,
  output renamePkg::flCount_t                 count_o
);

  import renamePkg::*;

  phyReg_t             freeMem [FREE_LIST_SIZE];
  logic [FL_PTR_W-1:0] head;     // speculative
  logic [FL_PTR_W-1:0] retHead;  // retired
  logic [FL_PTR_W-1:0] tail;
  flCount_t            count;

  flCount_t            allocOfs [RENAME_WIDTH];
  flCount_t            allocCnt;
  flCount_t            commitOfs [RENAME_WIDTH];
  flCount_t            commitCnt;

  // prefix counts over the slots and the commit ports
  always_comb
  begin
    allocCnt  = '0;
    commitCnt = '0;
    for (int k = 0; k < RENAME_WIDTH; k++)
    begin
      allocOfs[k]  = allocCnt;
      commitOfs[k] = commitCnt;
      allocCnt     = allocCnt + flCount_t'(destMask_i[k]);
      commitCnt    = commitCnt + flCount_t'(commitGroup_i[k].valid);
    end
  end

  // slot k skips the entries taken by earlier destination slots
  always_comb
  begin
    for (int k = 0; k < RENAME_WIDTH; k++)
      freeRegs_o[k] = freeMem[head + FL_PTR_W'(allocOfs[k])];
  end

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      head    <= '0;
      retHead <= '0;
      tail    <= '0;
      count   <= flCount_t'(FREE_LIST_SIZE);
    end
    else
    begin
      tail    <= tail + FL_PTR_W'(commitCnt);
      retHead <= retHead + FL_PTR_W'(commitCnt);  // commits arrive in order
      if (recoverFlag_i)
      begin
        // each commit frees one and retires one, so the retired list stays full
        head  <= retHead + FL_PTR_W'(commitCnt);
        count <= flCount_t'(FREE_LIST_SIZE);
      end
      else if (allocate_i)
      begin
        head  <= head + FL_PTR_W'(allocCnt);
        count <= count - allocCnt + commitCnt;
      end
      else
      begin
        count <= count + commitCnt;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      for (int i = 0; i < FREE_LIST_SIZE; i++)
        freeMem[i] <= phyReg_t'(NUM_LOGICAL + i);  // r32 .. r63 ascending
    end
    else
    begin
      for (int k = 0; k < RENAME_WIDTH; k++)
      begin
        if (commitGroup_i[k].valid)
          freeMem[tail + FL_PTR_W'(commitOfs[k])] <= commitGroup_i[k].phyReg;
      end
    end
  end

  assign count_o = count;

endmodule
